/* logic/pin_mux_pkg.sv */
/*
 * Pin routing package: pad counts, pad indices, JTAG tie-offs and core
 * reset hold length shared by the pin mux blocks
 */
package pin_mux_pkg;

  // Pad counts
  localparam int NumMioPads = 32;
  localparam int NumDioPads = 15;

  typedef logic [NumMioPads-1:0] mio_vec_t;
  typedef logic [NumDioPads-1:0] dio_vec_t;

  // Multiplexed pad indices
  localparam int JtagEnMioIdx  = 16;
  localparam int TrstMioIdx    = 18;
  localparam int SrstMioIdx    = 19;
  // Board switch for the external USB PHY
  localparam int UphySelMioIdx = 2;

  // Dedicated pad indices, SPI pins double as JTAG
  localparam int DioSckIdx         = 14;
  localparam int DioCsbIdx         = 13;
  localparam int DioSdiIdx         = 12;
  localparam int DioSdoIdx         = 11;
  localparam int DioUsbSenseIdx    = 8;
  localparam int DioUsbDpPullupIdx = 6;
  localparam int DioUsbDnPullupIdx = 5;
  localparam int DioUsbDIdx        = 2;
  localparam int DioUsbDpIdx       = 1;
  localparam int DioUsbDnIdx       = 0;

  // Pins taken over by JTAG
  localparam dio_vec_t DioJtagMask = dio_vec_t'((32'd1 << DioSckIdx) | (32'd1 << DioCsbIdx) |
                                                (32'd1 << DioSdiIdx) | (32'd1 << DioSdoIdx));
  localparam mio_vec_t MioJtagMask = mio_vec_t'((32'd1 << TrstMioIdx) | (32'd1 << SrstMioIdx));

  // Core view of taken pins, chip select is active low
  localparam dio_vec_t DioJtagTieOff = dio_vec_t'(32'd1 << DioCsbIdx);

  // Core reset stretch after all causes clear
  localparam int RstHoldCycles = 8;
  localparam int RstCntWidth   = $clog2(RstHoldCycles + 1);

endpackage : pin_mux_pkg

/* logic/jtag_overlay_mux.sv */
/*
 * JTAG overlay mux: strap pin hands the SPI pins and two GPIOs to JTAG
 */
`timescale 1ns/100ps

module jtag_overlay_mux import pin_mux_pkg::*; (
  // Core side, multiplexed pads
  input  mio_vec_t mio_out_core_i,
  input  mio_vec_t mio_oe_core_i,
  output mio_vec_t mio_in_core_o,
  // Core side, dedicated pads via the USB swap
  input  dio_vec_t dio_out_umux_i,
  input  dio_vec_t dio_oe_umux_i,
  output dio_vec_t dio_in_umux_o,
  // Pad side
  output mio_vec_t mio_out_pad_o,
  output mio_vec_t mio_oe_pad_o,
  input  mio_vec_t mio_in_pad_i,
  output dio_vec_t dio_out_pad_o,
  output dio_vec_t dio_oe_pad_o,
  input  dio_vec_t dio_in_pad_i,
  // JTAG
  output logic     jtag_tck_o,
  output logic     jtag_tms_o,
  output logic     jtag_tdi_o,
  output logic     jtag_trst_n_o,
  input  logic     jtag_tdo_i,
  output logic     jtag_srst_req_o
);

  logic jtag_en;

  // Strap is sampled straight from the pad
  assign jtag_en = mio_in_pad_i[JtagEnMioIdx];

  ////////////////////////////////////////
  // JTAG signals
  ////////////////////////////////////////

  // Idle low when the strap is off
  assign jtag_tck_o = jtag_en & dio_in_pad_i[DioSckIdx];
  assign jtag_tms_o = jtag_en & dio_in_pad_i[DioCsbIdx];
  assign jtag_tdi_o = jtag_en & dio_in_pad_i[DioSdiIdx];

  // Test reset held inactive without JTAG
  assign jtag_trst_n_o = jtag_en ? mio_in_pad_i[TrstMioIdx] : 1'b1;

  // Pad is active low, request is active high
  assign jtag_srst_req_o = jtag_en & ~mio_in_pad_i[SrstMioIdx];

  ////////////////////////////////////////
  // Pad routing
  ////////////////////////////////////////

  always_comb begin
    // Default pass-through
    mio_out_pad_o = mio_out_core_i;
    mio_oe_pad_o  = mio_oe_core_i;
    mio_in_core_o = mio_in_pad_i;
    dio_out_pad_o = dio_out_umux_i;
    dio_oe_pad_o  = dio_oe_umux_i;
    dio_in_umux_o = dio_in_pad_i;

    if (jtag_en) begin
      // Taken pins become inputs to the pads
      mio_oe_pad_o = mio_oe_core_i & ~MioJtagMask;
      dio_oe_pad_o = dio_oe_umux_i & ~DioJtagMask;

      // TDO is the one pin driven by JTAG
      dio_out_pad_o[DioSdoIdx] = jtag_tdo_i;
      dio_oe_pad_o[DioSdoIdx]  = 1'b1;

      // Core sees idle values on the taken pins
      mio_in_core_o = mio_in_pad_i & ~MioJtagMask;
      dio_in_umux_o = (dio_in_pad_i & ~DioJtagMask) | (DioJtagTieOff & DioJtagMask);
    end
  end

endmodule : jtag_overlay_mux

/* logic/usb_pin_swap.sv */
/*
 * USB pin swap: undoes the D+/D- flip of the core and optionally
 * takes the USB inputs from an external PHY
 */
`timescale 1ns/100ps

module usb_pin_swap import pin_mux_pkg::*; (
  // Core side
  input  dio_vec_t dio_out_core_i,
  input  dio_vec_t dio_oe_core_i,
  output dio_vec_t dio_in_core_o,
  // Toward the JTAG mux
  output dio_vec_t dio_out_umux_o,
  output dio_vec_t dio_oe_umux_o,
  input  dio_vec_t dio_in_umux_i,
  // External PHY
  input  logic     use_uphy_i,
  input  logic     uphy_dp_rx_i,
  input  logic     uphy_dn_rx_i,
  input  logic     uphy_d_rx_i,
  input  logic     uphy_sense_i,
  output logic     uphy_dp_tx_o,
  output logic     uphy_dn_tx_o,
  output logic     uphy_dppullup_o,
  output logic     uphy_oe_n_o
);

  logic undo_swap;
  logic rx_dp, rx_dn, rx_d;

  // Core flips the pins by enabling the D- pullup
  assign undo_swap = dio_oe_core_i[DioUsbDnPullupIdx];

  // Receive source before the swap
  assign rx_dp = use_uphy_i ? uphy_dp_rx_i : dio_in_umux_i[DioUsbDpIdx];
  assign rx_dn = use_uphy_i ? uphy_dn_rx_i : dio_in_umux_i[DioUsbDnIdx];
  assign rx_d  = use_uphy_i ? uphy_d_rx_i  : dio_in_umux_i[DioUsbDIdx];

  ////////////////////////////////////////
  // Swap toward the pads
  ////////////////////////////////////////

  always_comb begin
    dio_out_umux_o = dio_out_core_i;
    dio_oe_umux_o  = dio_oe_core_i;

    if (undo_swap) begin
      dio_out_umux_o[DioUsbDpIdx] = dio_out_core_i[DioUsbDnIdx];
      dio_out_umux_o[DioUsbDnIdx] = dio_out_core_i[DioUsbDpIdx];
      dio_oe_umux_o[DioUsbDpIdx]  = dio_oe_core_i[DioUsbDnIdx];
      dio_oe_umux_o[DioUsbDnIdx]  = dio_oe_core_i[DioUsbDpIdx];

      dio_out_umux_o[DioUsbDpPullupIdx] = dio_out_core_i[DioUsbDnPullupIdx];
      dio_out_umux_o[DioUsbDnPullupIdx] = dio_out_core_i[DioUsbDpPullupIdx];
      dio_oe_umux_o[DioUsbDpPullupIdx]  = dio_oe_core_i[DioUsbDnPullupIdx];
      dio_oe_umux_o[DioUsbDnPullupIdx]  = dio_oe_core_i[DioUsbDpPullupIdx];

      // Single-ended data flips polarity with the pair
      dio_out_umux_o[DioUsbDIdx] = ~dio_out_core_i[DioUsbDIdx];
    end
  end

  ////////////////////////////////////////
  // Swap toward the core
  ////////////////////////////////////////

  always_comb begin
    dio_in_core_o = dio_in_umux_i;

    dio_in_core_o[DioUsbDpIdx] = undo_swap ? rx_dn : rx_dp;
    dio_in_core_o[DioUsbDnIdx] = undo_swap ? rx_dp : rx_dn;
    dio_in_core_o[DioUsbDIdx]  = undo_swap ? ~rx_d : rx_d;

    if (use_uphy_i) begin
      dio_in_core_o[DioUsbSenseIdx] = uphy_sense_i;
    end
  end

  // PHY outputs always follow the pad-side values
  assign uphy_dp_tx_o    = dio_out_umux_o[DioUsbDpIdx];
  assign uphy_dn_tx_o    = dio_out_umux_o[DioUsbDnIdx];
  assign uphy_dppullup_o = dio_out_umux_o[DioUsbDpPullupIdx] & dio_oe_umux_o[DioUsbDpPullupIdx];
  assign uphy_oe_n_o     = ~dio_oe_umux_o[DioUsbDpIdx];

endmodule : usb_pin_swap

/* logic/core_reset_gen.sv */
/*
 * Core reset generator: board reset plus synchronized JTAG system reset,
 * release stretched by a hold counter
 */
`timescale 1ns/100ps

module core_reset_gen import pin_mux_pkg::*; (
  input  logic clk_main_i,
  input  logic rst_i,
  input  logic jtag_srst_req_i,
  output logic core_rst_o
);

  logic                   srst_meta_q, srst_sync_q;
  logic                   rst_cause;
  logic [RstCntWidth-1:0] hold_cnt_q;

  // Two-flop synchronizer, request comes from an unrelated pin
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      srst_meta_q <= 1'b0;
      srst_sync_q <= 1'b0;
    end else begin
      srst_meta_q <= jtag_srst_req_i;
      srst_sync_q <= srst_meta_q;
    end
  end

  assign rst_cause = rst_i | srst_sync_q;

  // Reload while a cause is active, count down after
  always_ff @(posedge clk_main_i) begin
    if (rst_cause) begin
      hold_cnt_q <= RstCntWidth'(RstHoldCycles);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign core_rst_o = (hold_cnt_q != '0);

endmodule : core_reset_gen

/* logic/fpga_pin_mux.sv */
/*
 * FPGA pin mux top: JTAG overlay, USB pin swap and core reset between
 * the board pads and the SoC core
 */
`timescale 1ns/100ps

module fpga_pin_mux import pin_mux_pkg::*; (
  input  logic     clk_main_i,
  input  logic     rst_i,
  // Core side
  input  mio_vec_t mio_out_core_i,
  input  mio_vec_t mio_oe_core_i,
  output mio_vec_t mio_in_core_o,
  input  dio_vec_t dio_out_core_i,
  input  dio_vec_t dio_oe_core_i,
  output dio_vec_t dio_in_core_o,
  // Pad side
  output mio_vec_t mio_out_pad_o,
  output mio_vec_t mio_oe_pad_o,
  input  mio_vec_t mio_in_pad_i,
  output dio_vec_t dio_out_pad_o,
  output dio_vec_t dio_oe_pad_o,
  input  dio_vec_t dio_in_pad_i,
  // JTAG toward the core
  output logic     jtag_tck_o,
  output logic     jtag_tms_o,
  output logic     jtag_tdi_o,
  output logic     jtag_trst_n_o,
  input  logic     jtag_tdo_i,
  // External USB PHY
  input  logic     uphy_dp_rx_i,
  input  logic     uphy_dn_rx_i,
  input  logic     uphy_d_rx_i,
  input  logic     uphy_sense_i,
  output logic     uphy_dp_tx_o,
  output logic     uphy_dn_tx_o,
  output logic     uphy_dppullup_o,
  output logic     uphy_oe_n_o,
  // Core reset
  output logic     core_rst_o
);

  // Dedicated vectors between the two muxes
  dio_vec_t dio_out_umux, dio_oe_umux, dio_in_umux;
  logic     jtag_srst_req;

  ////////////////////////////////////////
  // Pads to JTAG overlay
  ////////////////////////////////////////

  jtag_overlay_mux u_jtag_overlay_mux (
    .mio_out_core_i  (mio_out_core_i),
    .mio_oe_core_i   (mio_oe_core_i),
    .mio_in_core_o   (mio_in_core_o),
    .dio_out_umux_i  (dio_out_umux),
    .dio_oe_umux_i   (dio_oe_umux),
    .dio_in_umux_o   (dio_in_umux),
    .mio_out_pad_o   (mio_out_pad_o),
    .mio_oe_pad_o    (mio_oe_pad_o),
    .mio_in_pad_i    (mio_in_pad_i),
    .dio_out_pad_o   (dio_out_pad_o),
    .dio_oe_pad_o    (dio_oe_pad_o),
    .dio_in_pad_i    (dio_in_pad_i),
    .jtag_tck_o      (jtag_tck_o),
    .jtag_tms_o      (jtag_tms_o),
    .jtag_tdi_o      (jtag_tdi_o),
    .jtag_trst_n_o   (jtag_trst_n_o),
    .jtag_tdo_i      (jtag_tdo_i),
    .jtag_srst_req_o (jtag_srst_req)
  );

  ////////////////////////////////////////
  // USB swap toward the core
  ////////////////////////////////////////

  // PHY select switch read from the raw pad
  usb_pin_swap u_usb_pin_swap (
    .dio_out_core_i  (dio_out_core_i),
    .dio_oe_core_i   (dio_oe_core_i),
    .dio_in_core_o   (dio_in_core_o),
    .dio_out_umux_o  (dio_out_umux),
    .dio_oe_umux_o   (dio_oe_umux),
    .dio_in_umux_i   (dio_in_umux),
    .use_uphy_i      (mio_in_pad_i[UphySelMioIdx]),
    .uphy_dp_rx_i    (uphy_dp_rx_i),
    .uphy_dn_rx_i    (uphy_dn_rx_i),
    .uphy_d_rx_i     (uphy_d_rx_i),
    .uphy_sense_i    (uphy_sense_i),
    .uphy_dp_tx_o    (uphy_dp_tx_o),
    .uphy_dn_tx_o    (uphy_dn_tx_o),
    .uphy_dppullup_o (uphy_dppullup_o),
    .uphy_oe_n_o     (uphy_oe_n_o)
  );

  // Core reset
  core_reset_gen u_core_reset_gen (
    .clk_main_i      (clk_main_i),
    .rst_i           (rst_i),
    .jtag_srst_req_i (jtag_srst_req),
    .core_rst_o      (core_rst_o)
  );

endmodule : fpga_pin_mux

/* test/fpga_pin_mux_properties.sv */
/*
 * Concurrent checks on the pin mux top: JTAG clock idle, PHY output
 * enable and core reset during board reset
 */
`timescale 1ns/100ps

module fpga_pin_mux_properties import pin_mux_pkg::*; (
  input logic     clk_i,
  input logic     rst_i,
  input mio_vec_t mio_in_pad_i,
  input dio_vec_t dio_oe_core_i,
  input logic     jtag_tck_i,
  input logic     uphy_oe_n_i,
  input logic     core_rst_i
);

  logic inner_dp_oe;

  // Core D- enable lands on the D+ pad when the D- pullup undoes the swap
  assign inner_dp_oe = dio_oe_core_i[DioUsbDnPullupIdx] ? dio_oe_core_i[DioUsbDnIdx]
                                                        : dio_oe_core_i[DioUsbDpIdx];

  // TCK stays low without the strap
  a_tck_idle: assert property (@(posedge clk_i)
    !mio_in_pad_i[JtagEnMioIdx] |-> !jtag_tck_i)
    else $error("JTAG clock high while the strap pin is low");

  // PHY enable follows the inner D+ enable, active low
  a_uphy_oe: assert property (@(posedge clk_i)
    uphy_oe_n_i == ~inner_dp_oe)
    else $error("uphy_oe_n_o does not match the inner D+ output enable");

  a_core_rst: assert property (@(posedge clk_i) rst_i |=> core_rst_i)
    else $error("core_rst_o low one cycle after board reset");

endmodule : fpga_pin_mux_properties

bind fpga_pin_mux fpga_pin_mux_properties u_fpga_pin_mux_properties (
  .clk_i         (clk_main_i),
  .rst_i         (rst_i),
  .mio_in_pad_i  (mio_in_pad_i),
  .dio_oe_core_i (dio_oe_core_i),
  .jtag_tck_i    (jtag_tck_o),
  .uphy_oe_n_i   (uphy_oe_n_o),
  .core_rst_i    (core_rst_o)
);

/* test/tb_clock_gen.sv */
/*
 * Testbench clock source, 20 ns period
 */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

endmodule : tb_clock_gen

/* test/tb_fpga_pin_mux.sv */
/*
 * Pin mux testbench: vector-driven routing checks, board reset release
 * timing and the JTAG system reset path
 */
`timescale 1ns/100ps

module tb_fpga_pin_mux import pin_mux_pkg::*; ();

  localparam string VecFile        = "test/pin_mux_vectors.txt";
  localparam int    NumFields      = 15;
  localparam int    MaxLines       = 64;
  localparam int    RstCycles      = 16;
  localparam int    HoldTimeout    = RstHoldCycles + 4;
  localparam int    RiseTimeout    = 6;
  // Synchronizer adds two cycles to the hold
  localparam int    ReleaseMin     = RstHoldCycles + 1;
  localparam int    ReleaseTimeout = RstHoldCycles + 3;

  logic     clk_main_i, rst_i;
  mio_vec_t mio_out_core_i, mio_oe_core_i, mio_in_core_o;
  dio_vec_t dio_out_core_i, dio_oe_core_i, dio_in_core_o;
  mio_vec_t mio_out_pad_o, mio_oe_pad_o, mio_in_pad_i;
  dio_vec_t dio_out_pad_o, dio_oe_pad_o, dio_in_pad_i;
  logic     jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_tdo_i;
  logic     uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i;
  logic     uphy_dp_tx_o, uphy_dn_tx_o, uphy_dppullup_o, uphy_oe_n_o;
  logic     core_rst_o;

  logic [31:0] fld [NumFields];
  mio_vec_t    rnd_bits;
  int          errors, timeouts, checks;

  tb_clock_gen u_clk_gen (.clk_o(clk_main_i));

  // Testbench signals carry the port names
  fpga_pin_mux dut0 (.*);

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_mio(input string name, input mio_vec_t act, input mio_vec_t exp);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
      errors++;
    end
  endtask

  task automatic check_dio(input string name, input dio_vec_t act, input dio_vec_t exp);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Vector handling
  ////////////////////////////////////////

  // Don't-care bits of mio_out get random values, which pass straight through
  task automatic apply_case();
    mio_vec_t dc;
    dc             = fld[1];
    rnd_bits       = $urandom() & dc;
    mio_out_core_i = (fld[0] & ~dc) | rnd_bits;
    mio_oe_core_i  = fld[2];
    mio_in_pad_i   = fld[3];
    dio_out_core_i = dio_vec_t'(fld[4]);
    dio_oe_core_i  = dio_vec_t'(fld[5]);
    dio_in_pad_i   = dio_vec_t'(fld[6]);
    jtag_tdo_i     = fld[7][4];
    uphy_dp_rx_i   = fld[7][3];
    uphy_dn_rx_i   = fld[7][2];
    uphy_d_rx_i    = fld[7][1];
    uphy_sense_i   = fld[7][0];
  endtask

  // misc_out bits from 7 down: tck tms tdi trst_n dp_tx dn_tx dppullup oe_n
  task automatic check_case();
    mio_vec_t   dc;
    logic [7:0] exp_misc;
    dc       = fld[1];
    exp_misc = fld[14][7:0];
    check_mio("mio_in_core_o", mio_in_core_o, fld[8]);
    check_mio("mio_out_pad_o", mio_out_pad_o, (fld[9] & ~dc) | rnd_bits);
    check_mio("mio_oe_pad_o", mio_oe_pad_o, fld[10]);
    check_dio("dio_in_core_o", dio_in_core_o, dio_vec_t'(fld[11]));
    check_dio("dio_out_pad_o", dio_out_pad_o, dio_vec_t'(fld[12]));
    check_dio("dio_oe_pad_o", dio_oe_pad_o, dio_vec_t'(fld[13]));
    check_bit("jtag_tck_o", jtag_tck_o, exp_misc[7]);
    check_bit("jtag_tms_o", jtag_tms_o, exp_misc[6]);
    check_bit("jtag_tdi_o", jtag_tdi_o, exp_misc[5]);
    check_bit("jtag_trst_n_o", jtag_trst_n_o, exp_misc[4]);
    check_bit("uphy_dp_tx_o", uphy_dp_tx_o, exp_misc[3]);
    check_bit("uphy_dn_tx_o", uphy_dn_tx_o, exp_misc[2]);
    check_bit("uphy_dppullup_o", uphy_dppullup_o, exp_misc[1]);
    check_bit("uphy_oe_n_o", uphy_oe_n_o, exp_misc[0]);
  endtask

  // Counts rising edges until core reset reaches the level
  task automatic wait_core_rst(input logic level, input int limit, output int edges,
                               output bit ok);
    edges = 0;
    ok    = 1'b0;
    while (!ok && edges < limit) begin
      @(posedge clk_main_i);
      edges++;
      @(negedge clk_main_i);
      if (core_rst_o === level) ok = 1'b1;
    end
    if (!ok) begin
      $display("Timeout: core_rst_o did not reach %0b within %0d cycles", level, limit);
      timeouts++;
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          n_lines;
    int          n_cases;
    int          edges;
    bit          ok;
    string       line;
    void'($urandom(32'he618));
    errors         = 0;
    timeouts       = 0;
    checks         = 0;
    rnd_bits       = '0;
    rst_i          = 1'b1;
    mio_out_core_i = '0;
    mio_oe_core_i  = '0;
    mio_in_pad_i   = '0;
    dio_out_core_i = '0;
    dio_oe_core_i  = '0;
    dio_in_pad_i   = '0;
    jtag_tdo_i     = 1'b0;
    uphy_dp_rx_i   = 1'b0;
    uphy_dn_rx_i   = 1'b0;
    uphy_d_rx_i    = 1'b0;
    uphy_sense_i   = 1'b0;

    // Board reset release and hold
    repeat (RstCycles) @(posedge clk_main_i);
    #2;
    rst_i = 1'b0;
    wait_core_rst(1'b0, HoldTimeout, edges, ok);
    if (ok && edges != RstHoldCycles) begin
      $display("Core reset released %0d cycles after board reset instead of %0d",
               edges, RstHoldCycles);
      errors++;
    end

    ////////////////////////////////////////
    // Routing vectors
    ////////////////////////////////////////
    n_cases = 0;
    fd      = $fopen(VecFile, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VecFile);
      errors++;
    end else begin
      n_lines = 0;
      while (!$feof(fd) && n_lines < MaxLines) begin
        code = $fgets(line, fd);
        n_lines++;
        if (code > 0) begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                         fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
        end
        // Comment and blank lines fall out here
        if (code == NumFields) begin
          @(posedge clk_main_i);
          #2;
          apply_case();
          @(negedge clk_main_i);
          check_case();
          check_bit("core_rst_o", core_rst_o, 1'b0);
          n_cases++;
        end
      end
      $fclose(fd);
      if (n_cases == 0) begin
        $display("No test vectors found in %s", VecFile);
        errors++;
      end
    end

    // System reset request through the SRST pin, active low
    @(posedge clk_main_i);
    #2;
    mio_in_pad_i               = '0;
    mio_in_pad_i[JtagEnMioIdx] = 1'b1;
    wait_core_rst(1'b1, RiseTimeout, edges, ok);
    @(posedge clk_main_i);
    #2;
    mio_in_pad_i[SrstMioIdx] = 1'b1;
    wait_core_rst(1'b0, ReleaseTimeout, edges, ok);
    if (ok && edges < ReleaseMin) begin
      $display("Core reset released %0d cycles after the system reset pin, too early",
               edges);
      errors++;
    end

    $display("Vectors: %0d, checks: %0d, mismatches: %0d, timeouts: %0d",
             n_cases, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_fpga_pin_mux

/* fpga_pin_mux.f */
logic/pin_mux_pkg.sv
logic/jtag_overlay_mux.sv
logic/usb_pin_swap.sv
logic/core_reset_gen.sv
logic/fpga_pin_mux.sv
test/fpga_pin_mux_properties.sv
test/tb_clock_gen.sv
test/tb_fpga_pin_mux.sv

/* run_sim.sh */
#!/bin/bash
# Builds the pin mux testbench with Verilator, runs it and checks the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_fpga_pin_mux \
  -f fpga_pin_mux.f

./obj_dir/Vtb_fpga_pin_mux | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  echo "run_sim.sh: testbench reported failure, see sim.log"
  exit 1
fi

/* test/pin_mux_vectors.txt */
// in:  mio_out mio_dc mio_oe mio_pad_in dio_out dio_oe dio_pad_in misc_in(tdo,dp,dn,d,sense)
// exp: mio_core_in mio_pad_out mio_pad_oe dio_core_in dio_pad_out dio_pad_oe misc_out(8 bits)
// Strap low, everything passes through
A5A5A5A5 0000FF00 FFFF0000 12348008 5A5A 3C1A 6A55 15 12348008 A5A5A5A5 FFFF0000 6A55 5A5A 3C1A 18
0F0F1234 00000000 00FF00FF FFFEFFFB 0000 7FDF 7FFF 00 FFFEFFFB 0F0F1234 00FF00FF 7FFF 0000 7FDF 10
// Strap high, SPI pins and two GPIOs taken by JTAG
FFFFFFFF FF000000 FFFFFFFF 5509A011 0000 7FDF 5333 10 5501A011 FFFFFFFF FFF3FFFF 2333 0800 0FDF A0
12345678 00000000 000C0000 000D0000 7FFF 7800 6800 00 00010000 12345678 00000000 2000 77FF 0800 DD
// D- pullup enable undoes the swap
00000000 FFFFFFFF 00000000 00000000 0422 0026 0306 0F 00000000 00000000 00000000 0301 0445 0045 17
// External PHY, without and with swap
DEADBEEF 00000000 CAFEF00D 00000004 0043 0042 0107 04 00000004 DEADBEEF CAFEF00D 0001 0043 0042 1E
00000000 0000FFFF 00000000 00000004 0041 0021 0000 0B 00000004 00000000 00000000 0101 0026 0042 18
// JTAG, swap and PHY together
FFFF0000 00000000 FFFFFFFF 00090004 7FFF 0020 7FFF 0C 00010004 FFFF0000 FFF3FFFF 26FF 77FB 0840 EF
